//--- ack_ctrl_cfg.svh
// timeouts are in clock cycles; NUM_CLK_PER_US suits simulation only, set it for the real clock
`ifndef ACK_CTRL_CFG_SVH
`define ACK_CTRL_CFG_SVH

// field widths
`define MAC_ADDR_W 48
`define DUR_W 16
`define RETRY_W 4

// shared timeout counter, counts clocks directly
`define TIMER_W 15

// phy side word and read address
`define TX_WORD_W 64
`define BRAM_ADDR_W 10

// ack/cts frame is 14 bytes incl fcs
`define ACK_SIGNAL_LEN 14

// ack/cts always goes out at 6 Mbps
`define ACK_RATE_CODE 4'b1011

// 6 Mbps, 14 bytes -> (22 + 14*8) / 24 rounded up
`define ACK_N_SYM 6

// clocks per microsecond
`define NUM_CLK_PER_US 10

`endif

//--- ack_ctrl_pkg.sv
// types only; widths come from the cfg macros, so the header must be visible here
`include "ack_ctrl_cfg.svh"

package ack_ctrl_pkg;

  // controller states
  typedef enum logic [3:0] {
    IDLE,
    PREP_ACK,
    SEND_ACK,
    RECV_ACK_JUDGE,
    RECV_ACK_WAIT_TX_BB_DONE,
    RECV_ACK_WAIT_SIG_VALID,
    RECV_ACK,
    RECV_ACK_WAIT_BACKOFF_DONE
  } ctrl_state_e;

  // decoded kind of the received frame
  typedef enum logic [2:0] {
    FK_DATA,
    FK_QOS_DATA,
    FK_MGMT,
    FK_PSPOLL,
    FK_RTS,
    FK_ACK,
    FK_OTHER
  } frame_kind_e;

  // fields from the rx parser, sampled each cycle
  typedef struct packed {
    logic [1:0]             fc_type;
    logic [3:0]             fc_subtype;
    logic                   more_frag;
    logic [`DUR_W-1:0]      duration;
    logic [`MAC_ADDR_W-1:0] addr1;
    logic [`MAC_ADDR_W-1:0] addr2;
    logic [15:0]            signal_len;
    logic                   sig_valid;
    logic                   fcs_valid;
    logic                   fcs_in_strobe;
    logic [1:0]             qos_ack_policy;
  } rx_frame_t;

  // software timing, all in clocks
  typedef struct packed {
    logic [6:0]          preamble_sig_time;
    logic [4:0]          ofdm_symbol_time;
    logic [6:0]          sifs_time;
    logic [`TIMER_W-1:0] send_ack_wait_top;
    logic [`TIMER_W-1:0] recv_ack_sig_valid_timeout_top;
    logic [`TIMER_W-1:0] recv_ack_timeout_top_adj;
    logic [`RETRY_W-1:0] max_num_retrans;
  } timing_cfg_t;

  // what the ack/cts response needs from the received frame
  typedef struct packed {
    logic [`MAC_ADDR_W-1:0] ack_addr;
    logic [`DUR_W-1:0]      rx_duration;
    logic                   is_rts;
    logic                   dur_from_rx;
  } ack_resp_t;

  // result of one tx try
  typedef struct packed {
    logic                acked;
    logic [`RETRY_W-1:0] num_retrans;
  } tx_status_t;

endpackage

//--- ack_ctrl_tb.sv
// assumes NUM_CLK_PER_US of 10 and the small timing set below; the run is capped at 4000 cycles
`timescale 1ns/1ns
`include "ack_ctrl_cfg.svh"

module ack_ctrl_tb;
  import ack_ctrl_pkg::*;

  // timing set in clocks and duration units
  localparam int wait_top = 3;
  localparam int preamble = 20;
  localparam int ofdm_sym = 4;
  localparam int sifs = 16;
  localparam int max_cycles = 4000;
  localparam logic [47:0] self_mac = 48'h0200_1122_3344;

  logic clk;
  logic reset_blk_ack_bitmap_mem;
  rx_frame_t rx;
  timing_cfg_t tcfg;
  logic [`MAC_ADDR_W-1:0] self_mac_addr;
  logic [`DUR_W-1:0] duration_extra;
  logic [`BRAM_ADDR_W-1:0] bram_addr;
  logic ack_disable, cts_torts_disable, recv_ack_fcs_valid_disable;
  logic tx_pkt_need_ack;
  logic [`RETRY_W-1:0] tx_pkt_retrans_limit;
  logic phy_tx_done, pulse_tx_bb_end, cts_toself_bb_is_ongoing, backoff_done, quit_retrans;
  logic tx_control_state_idle, ack_cts_is_ongoing, retrans_in_progress;
  logic start_tx_ack, retrans_trigger, start_retrans, tx_try_complete;
  tx_status_t tx_status;
  logic [`TX_WORD_W-1:0] dina;

  // reference model state
  logic [47:0] exp_addr2;
  logic [15:0] exp_dur;
  logic exp_is_rts;
  logic [`TX_WORD_W-1:0] exp_dina;
  logic read_en, dina_chk;
  tx_status_t exp_status;
  logic complete_expected, trigger_allowed, no_resp_expected;
  integer seed;
  int cycle_count;
  int r;
  logic [15:0] dur_r, extra_r;

  ack_ctrl_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_and_stop();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic mismatch_error(input string name, input logic [63:0] expv,
                                input logic [63:0] actv);
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expv, actv);
    fail_and_stop();
  endtask

  task automatic plain_error(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    fail_and_stop();
  endtask

  // 802.11 signal field and ack/cts header words as the phy reads them
  function automatic logic [63:0] expected_word(input logic [9:0] addr);
    logic [63:0] w;
    logic [16:0] sig;
    logic [15:0] fc;
    w = '0;
    // rate, reserved bit and 12 bit length
    sig = {12'(`ACK_SIGNAL_LEN), 1'b0, 4'(`ACK_RATE_CODE)};
    // 0x00c4 is cts and 0x00d4 is ack
    fc = exp_is_rts ? 16'h00c4 : 16'h00d4;
    if (addr == 10'd0) w = {46'd0, ^sig, sig};
    else if (addr == 10'd2) w = {exp_addr2[31:0], exp_dur, fc};
    else if (addr == 10'd3) w = {48'd0, exp_addr2[47:32]};
    return w;
  endfunction

  // extra plus rx duration less ack airtime and sifs and never below extra
  function automatic logic [15:0] expected_duration(input logic [15:0] dur,
                                                    input logic [15:0] extra,
                                                    input logic from_rx);
    int eff;
    int rest;
    eff = dur[15] ? 0 : int'(dur);
    rest = eff - (preamble + `ACK_N_SYM * ofdm_sym) - sifs;
    if (!from_rx || rest < 0) rest = 0;
    return extra + 16'(rest);
  endfunction

  function automatic rx_frame_t idle_frame();
    rx_frame_t f;
    f = '0;
    // reserved type decodes to nothing
    f.fc_type = 2'b11;
    return f;
  endfunction

  function automatic rx_frame_t make_frame(input logic [1:0] ftype, input logic [3:0] sub,
                                           input logic [15:0] len, input logic [47:0] dest,
                                           input logic [47:0] src, input logic [15:0] dur);
    rx_frame_t f;
    f = idle_frame();
    f.fc_type = ftype;
    f.fc_subtype = sub;
    f.signal_len = len;
    f.addr1 = dest;
    f.addr2 = src;
    f.duration = dur;
    f.fcs_valid = 1'b1;
    return f;
  endfunction

  // responder round with frame in, sifs wait, phy reads of words 0..4 and tx done
  task automatic respond(input logic is_rts, input logic [15:0] dur, input logic [15:0] extra);
    logic [47:0] src;
    rx_frame_t f;
    int a;
    src[31:0] = $random(seed);
    src[47:32] = 16'($random(seed));
    if (is_rts) f = make_frame(2'b01, 4'b1011, 16'd20, self_mac, src, dur);
    else f = make_frame(2'b10, 4'b0000, 16'd60, self_mac, src, dur);
    @(posedge clk);
    rx <= f;
    duration_extra <= extra;
    exp_addr2 <= src;
    exp_is_rts <= is_rts;
    exp_dur <= expected_duration(dur, extra, is_rts);
    @(posedge clk);
    rx <= idle_frame();
    do @(posedge clk); while (!start_tx_ack);
    for (a = 0; a < 5; a++) begin
      @(posedge clk);
      bram_addr <= 10'(a);
      read_en <= 1'b1;
    end
    @(posedge clk);
    read_en <= 1'b0;
    @(posedge clk);
    phy_tx_done <= 1'b1;
    @(posedge clk);
    phy_tx_done <= 1'b0;
    do @(posedge clk); while (ack_cts_is_ongoing);
  endtask

  task automatic no_response(input logic [47:0] dest, input logic disable_ack);
    @(posedge clk);
    rx <= make_frame(2'b01, 4'b1011, 16'd20, dest, 48'h0a0b_0c0d_0e0f, 16'd300);
    ack_disable <= disable_ack;
    no_resp_expected <= 1'b1;
    @(posedge clk);
    rx <= idle_frame();
    repeat (4) @(posedge clk);
    no_resp_expected <= 1'b0;
    ack_disable <= 1'b0;
  endtask

  task automatic own_tx_end(input logic need_ack);
    @(posedge clk);
    tx_pkt_need_ack <= need_ack;
    phy_tx_done <= 1'b1;
    @(posedge clk);
    phy_tx_done <= 1'b0;
  endtask

  // bb end, then optional 14 byte signal, then optional ack to us
  task automatic ack_phase(input logic sig_seen, input logic ack_seen);
    rx_frame_t f;
    // judge state takes one cycle first
    repeat (2) @(posedge clk);
    pulse_tx_bb_end <= 1'b1;
    @(posedge clk);
    pulse_tx_bb_end <= 1'b0;
    if (sig_seen) begin
      repeat (3) @(posedge clk);
      f = idle_frame();
      f.sig_valid = 1'b1;
      f.signal_len = 16'd14;
      rx <= f;
      @(posedge clk);
      rx <= idle_frame();
      if (ack_seen) begin
        repeat (8) @(posedge clk);
        f = make_frame(2'b01, 4'b1101, 16'd14, self_mac, 48'd0, 16'd0);
        f.fcs_in_strobe = 1'b1;
        rx <= f;
        @(posedge clk);
        rx <= idle_frame();
      end
    end
  endtask

  task automatic wait_retrans_trigger();
    do @(posedge clk); while (!retrans_trigger);
    trigger_allowed <= 1'b0;
  endtask

  task automatic backoff_restart();
    @(posedge clk);
    backoff_done <= 1'b1;
    repeat (2) @(posedge clk);
    backoff_done <= 1'b0;
    do @(posedge clk); while (!start_retrans);
  endtask

  task automatic wait_try_complete();
    do @(posedge clk); while (!tx_try_complete);
    complete_expected <= 1'b0;
  endtask

  // word model runs one clock behind bram_addr
  always @(posedge clk) begin
    exp_dina <= expected_word(bram_addr);
    dina_chk <= read_en;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) plain_error("run did not finish within 4000 cycles");
  end

  a_reset_clear: assert property (@(posedge clk) $fell(reset_blk_ack_bitmap_mem) |->
    (tx_status == '0 && !tx_try_complete && !start_tx_ack && !retrans_trigger &&
     !start_retrans && !ack_cts_is_ongoing && !retrans_in_progress))
    else plain_error("outputs not cleared after reset");
  a_sifs_turnaround: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    $rose(ack_cts_is_ongoing) |-> !start_tx_ack [*(wait_top + 1)] ##1 start_tx_ack)
    else plain_error("start_tx_ack not seen wait_top + 1 cycles after ack_cts_is_ongoing rose");
  a_no_response: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    no_resp_expected |-> !ack_cts_is_ongoing)
    else mismatch_error("ack_cts_is_ongoing", 0, $sampled(ack_cts_is_ongoing));
  a_dina: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    dina_chk |-> dina == exp_dina)
    else mismatch_error("dina", $sampled(exp_dina), $sampled(dina));
  a_status: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    tx_try_complete |-> tx_status == exp_status)
    else mismatch_error("tx_status", $sampled(exp_status), $sampled(tx_status));
  a_complete_allowed: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    tx_try_complete |-> complete_expected)
    else plain_error("tx_try_complete pulsed when no try was due to end");
  a_rip_cleared: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    tx_try_complete |-> !retrans_in_progress)
    else mismatch_error("retrans_in_progress", 0, $sampled(retrans_in_progress));
  // controller is back to idle once a try has ended
  a_idle_after_try: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    tx_try_complete |-> tx_control_state_idle)
    else mismatch_error("tx_control_state_idle", 1, $sampled(tx_control_state_idle));
  // busy while answering a frame or once a retransmission has started
  a_busy_level: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    (start_retrans || ack_cts_is_ongoing) |-> !tx_control_state_idle)
    else mismatch_error("tx_control_state_idle", 0, $sampled(tx_control_state_idle));
  a_noack_done: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    (phy_tx_done && !tx_pkt_need_ack && !ack_cts_is_ongoing && !cts_toself_bb_is_ongoing)
    |-> ##2 tx_try_complete)
    else plain_error("tx_try_complete missing 2 cycles after phy_tx_done without ack");
  a_trigger_allowed: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    retrans_trigger |-> trigger_allowed)
    else mismatch_error("retrans_trigger", 0, 1);
  a_backoff_start: assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    (backoff_done && retrans_in_progress && tx_control_state_idle && !quit_retrans)
    |-> ##2 start_retrans)
    else plain_error("start_retrans missing 2 cycles after backoff_done");

  initial begin
    seed = 23;
    cycle_count = 0;
    reset_blk_ack_bitmap_mem = 1'b1;
    rx = idle_frame();
    tcfg = '{preamble_sig_time: 7'(preamble), ofdm_symbol_time: 5'(ofdm_sym),
             sifs_time: 7'(sifs), send_ack_wait_top: 15'(wait_top),
             recv_ack_sig_valid_timeout_top: 15'd20, recv_ack_timeout_top_adj: 15'd5,
             max_num_retrans: 4'd0};
    self_mac_addr = self_mac;
    duration_extra = '0;
    bram_addr = '0;
    ack_disable = 1'b0;
    cts_torts_disable = 1'b0;
    recv_ack_fcs_valid_disable = 1'b0;
    tx_pkt_need_ack = 1'b0;
    tx_pkt_retrans_limit = 4'd3;
    phy_tx_done = 1'b0;
    pulse_tx_bb_end = 1'b0;
    cts_toself_bb_is_ongoing = 1'b0;
    backoff_done = 1'b0;
    quit_retrans = 1'b0;
    exp_addr2 = '0;
    exp_dur = '0;
    exp_is_rts = 1'b0;
    read_en = 1'b0;
    exp_status = '0;
    complete_expected = 1'b0;
    trigger_allowed = 1'b0;
    no_resp_expected = 1'b0;
    repeat (5) @(posedge clk);
    reset_blk_ack_bitmap_mem <= 1'b0;
    repeat (2) @(posedge clk);

    // data frame whose ack carries duration_extra only
    dur_r = 16'($random(seed));
    extra_r = 16'($random(seed));
    respond(1'b0, dur_r & 16'h7fff, extra_r & 16'h00ff);
    // rts with long, short and negative durations
    dur_r = 16'($random(seed));
    extra_r = 16'($random(seed));
    respond(1'b1, dur_r & 16'h7fff, extra_r & 16'h00ff);
    dur_r = 16'($random(seed));
    extra_r = 16'($random(seed));
    respond(1'b1, dur_r & 16'h001f, extra_r & 16'h00ff);
    dur_r = 16'($random(seed));
    extra_r = 16'($random(seed));
    respond(1'b1, dur_r | 16'h8000, extra_r & 16'h00ff);
    no_response(self_mac ^ 48'h1, 1'b0);
    no_response(self_mac, 1'b1);

    // own frame without ack
    exp_status <= '{acked: 1'b1, num_retrans: 4'd0};
    complete_expected <= 1'b1;
    own_tx_end(1'b0);
    wait_try_complete();

    // one signal timeout then acked on the retry
    tx_pkt_retrans_limit <= 4'd3;
    trigger_allowed <= 1'b1;
    own_tx_end(1'b1);
    ack_phase(1'b0, 1'b0);
    wait_retrans_trigger();
    backoff_restart();
    exp_status <= '{acked: 1'b1, num_retrans: 4'd1};
    complete_expected <= 1'b1;
    own_tx_end(1'b1);
    ack_phase(1'b1, 1'b1);
    wait_try_complete();

    // ack timeouts until the limit of 2
    tx_pkt_retrans_limit <= 4'd2;
    for (r = 0; r < 3; r++) begin
      if (r < 2) begin
        trigger_allowed <= 1'b1;
      end else begin
        exp_status <= '{acked: 1'b0, num_retrans: 4'd2};
        complete_expected <= 1'b1;
      end
      own_tx_end(1'b1);
      ack_phase(1'b1, 1'b0);
      if (r < 2) begin
        wait_retrans_trigger();
        backoff_restart();
      end else begin
        wait_try_complete();
      end
    end

    // quit while a retry is pending
    trigger_allowed <= 1'b1;
    own_tx_end(1'b1);
    ack_phase(1'b0, 1'b0);
    wait_retrans_trigger();
    exp_status <= '{acked: 1'b0, num_retrans: 4'd1};
    complete_expected <= 1'b1;
    @(posedge clk);
    quit_retrans <= 1'b1;
    @(posedge clk);
    quit_retrans <= 1'b0;
    wait_try_complete();

    repeat (4) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- ack_ctrl_top.f
+incdir+.
ack_ctrl_pkg.sv
ack_frame_classifier.sv
ack_duration_calc.sv
ack_frame_builder.sv
tx_control_fsm.sv
ack_ctrl_top.sv
ack_ctrl_tb.sv

//--- ack_ctrl_top.sv
// pulses and levels only, no handshake; the phy must read ack words while ack_cts_is_ongoing
`timescale 1ns/1ns
`include "ack_ctrl_cfg.svh"

module ack_ctrl_top (
  input  logic                       clk,
  input  logic                       reset_blk_ack_bitmap_mem,
  input  ack_ctrl_pkg::rx_frame_t    rx,
  input  ack_ctrl_pkg::timing_cfg_t  tcfg,
  input  logic [`MAC_ADDR_W-1:0]     self_mac_addr,
  input  logic [`DUR_W-1:0]          duration_extra,
  input  logic [`BRAM_ADDR_W-1:0]    bram_addr,
  input  logic                       ack_disable,
  input  logic                       cts_torts_disable,
  input  logic                       recv_ack_fcs_valid_disable,
  input  logic                       tx_pkt_need_ack,
  input  logic [`RETRY_W-1:0]        tx_pkt_retrans_limit,
  input  logic                       phy_tx_done,
  input  logic                       pulse_tx_bb_end,
  input  logic                       cts_toself_bb_is_ongoing,
  input  logic                       backoff_done,
  input  logic                       quit_retrans,
  output logic                       tx_control_state_idle,
  output logic                       ack_cts_is_ongoing,
  output logic                       retrans_in_progress,
  output logic                       start_tx_ack,
  output logic                       retrans_trigger,
  output logic                       start_retrans,
  output logic                       tx_try_complete,
  output ack_ctrl_pkg::tx_status_t   tx_status,
  output logic [`TX_WORD_W-1:0]      dina
);
  import ack_ctrl_pkg::*;

  // classifier <-> fsm
  logic              ack_needed;
  logic              ack_for_me;
  logic              capture;
  // response path
  ack_resp_t         resp;
  logic [`DUR_W-1:0] duration_new;

  ack_frame_classifier classifier_i (
    .clk                      (clk),
    .reset_blk_ack_bitmap_mem (reset_blk_ack_bitmap_mem),
    .rx                       (rx),
    .self_mac_addr            (self_mac_addr),
    .cts_torts_disable        (cts_torts_disable),
    .capture                  (capture),
    .ack_needed               (ack_needed),
    .ack_for_me               (ack_for_me),
    .resp                     (resp)
  );

  ack_duration_calc duration_i (
    .clk                      (clk),
    .reset_blk_ack_bitmap_mem (reset_blk_ack_bitmap_mem),
    .resp                     (resp),
    .tcfg                     (tcfg),
    .duration_extra           (duration_extra),
    .duration_new             (duration_new)
  );

  ack_frame_builder builder_i (
    .clk                      (clk),
    .reset_blk_ack_bitmap_mem (reset_blk_ack_bitmap_mem),
    .bram_addr                (bram_addr),
    .resp                     (resp),
    .duration_new             (duration_new),
    .dina                     (dina)
  );

  tx_control_fsm fsm_i (
    .clk                        (clk),
    .reset_blk_ack_bitmap_mem   (reset_blk_ack_bitmap_mem),
    .tcfg                       (tcfg),
    .rx                         (rx),
    .ack_needed                 (ack_needed),
    .ack_for_me                 (ack_for_me),
    .ack_disable                (ack_disable),
    .recv_ack_fcs_valid_disable (recv_ack_fcs_valid_disable),
    .tx_pkt_need_ack            (tx_pkt_need_ack),
    .tx_pkt_retrans_limit       (tx_pkt_retrans_limit),
    .phy_tx_done                (phy_tx_done),
    .pulse_tx_bb_end            (pulse_tx_bb_end),
    .cts_toself_bb_is_ongoing   (cts_toself_bb_is_ongoing),
    .backoff_done               (backoff_done),
    .quit_retrans               (quit_retrans),
    .capture                    (capture),
    .tx_control_state_idle      (tx_control_state_idle),
    .ack_cts_is_ongoing         (ack_cts_is_ongoing),
    .retrans_in_progress        (retrans_in_progress),
    .start_tx_ack               (start_tx_ack),
    .retrans_trigger            (retrans_trigger),
    .start_retrans              (start_retrans),
    .tx_try_complete            (tx_try_complete),
    .tx_status                  (tx_status)
  );

endmodule

//--- ack_duration_calc.sv
// two cycle latency from resp/tcfg to duration_new; times in the same unit as the duration field
`timescale 1ns/1ns
`include "ack_ctrl_cfg.svh"

module ack_duration_calc (
  input  logic                       clk,
  input  logic                       reset_blk_ack_bitmap_mem,
  input  ack_ctrl_pkg::ack_resp_t    resp,
  input  ack_ctrl_pkg::timing_cfg_t  tcfg,
  input  logic [`DUR_W-1:0]          duration_extra,
  output logic [`DUR_W-1:0]          duration_new
);
  localparam logic [`DUR_W-1:0] n_sym = `ACK_N_SYM;

  // stage 1 regs
  logic [`DUR_W-1:0] airtime_q;
  logic [`DUR_W-1:0] sifs_q;
  logic [`DUR_W-1:0] rx_dur_q;
  logic [`DUR_W-1:0] extra_q;
  logic              from_rx_q;
  // stage 2 math
  logic [`DUR_W-1:0] overhead;
  logic [`DUR_W-1:0] rx_part;

  always_ff @(posedge clk) begin
    if (reset_blk_ack_bitmap_mem) begin
      airtime_q <= '0;
      sifs_q <= '0;
      rx_dur_q <= '0;
      extra_q <= '0;
      from_rx_q <= 1'b0;
    end else begin
      // preamble + signal, then n data symbols
      airtime_q <= {9'd0, tcfg.preamble_sig_time} + n_sym * {11'd0, tcfg.ofdm_symbol_time};
      sifs_q <= {9'd0, tcfg.sifs_time};
      rx_dur_q <= resp.rx_duration;
      extra_q <= duration_extra;
      from_rx_q <= resp.dur_from_rx;
    end
  end

  always_comb begin
    overhead = airtime_q + sifs_q;
    // clamp at zero instead of wrapping
    rx_part = (rx_dur_q > overhead) ? (rx_dur_q - overhead) : '0;
  end

  always_ff @(posedge clk) begin
    if (reset_blk_ack_bitmap_mem) begin
      duration_new <= '0;
    end else begin
      duration_new <= extra_q + (from_rx_q ? rx_part : '0);
    end
  end

endmodule

//--- ack_frame_builder.sv
// word appears one clock after bram_addr; only addresses 0, 2 and 3 carry data
`timescale 1ns/1ns
`include "ack_ctrl_cfg.svh"

module ack_frame_builder (
  input  logic                     clk,
  input  logic                     reset_blk_ack_bitmap_mem,
  input  logic [`BRAM_ADDR_W-1:0]  bram_addr,
  input  ack_ctrl_pkg::ack_resp_t  resp,
  input  logic [`DUR_W-1:0]        duration_new,
  output logic [`TX_WORD_W-1:0]    dina
);
  localparam logic [3:0]  rate = `ACK_RATE_CODE;
  localparam logic [11:0] sig_len = `ACK_SIGNAL_LEN;

  // word slots the phy reads
  localparam logic [`BRAM_ADDR_W-1:0] addr_signal = 0;
  localparam logic [`BRAM_ADDR_W-1:0] addr_fc = 2;
  localparam logic [`BRAM_ADDR_W-1:0] addr_ra_hi = 3;

  logic                  parity;
  logic [3:0]            subtype;
  logic [`TX_WORD_W-1:0] word_d;

  always_comb begin
    // even parity over rate and length
    parity = ^{sig_len, rate};
    // cts answers an rts, ack for everything else
    subtype = resp.is_rts ? 4'b1100 : 4'b1101;
    case (bram_addr)
      addr_signal: begin
        word_d = {32'h0, 14'd0, parity, sig_len, 1'b0, rate};
      end
      addr_fc: begin
        // fc type 01 is control, protocol version 0
        word_d = {resp.ack_addr[31:0], duration_new, 8'd0, subtype, 2'b01, 2'b00};
      end
      addr_ra_hi: begin
        word_d = {48'h0, resp.ack_addr[47:32]};
      end
      default: begin
        word_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_blk_ack_bitmap_mem) begin
      dina <= '0;
    end else begin
      dina <= word_d;
    end
  end

endmodule

//--- ack_frame_classifier.sv
// rx fields must be valid in the cycle they are sampled; no a-mpdu or block ack frames
`timescale 1ns/1ns
`include "ack_ctrl_cfg.svh"

module ack_frame_classifier (
  input  logic                      clk,
  input  logic                      reset_blk_ack_bitmap_mem,
  input  ack_ctrl_pkg::rx_frame_t   rx,
  input  logic [`MAC_ADDR_W-1:0]    self_mac_addr,
  input  logic                      cts_torts_disable,
  input  logic                      capture,
  output logic                      ack_needed,
  output logic                      ack_for_me,
  output ack_ctrl_pkg::ack_resp_t   resp
);
  import ack_ctrl_pkg::*;

  localparam logic [15:0] ack_len = `ACK_SIGNAL_LEN;

  frame_kind_e kind;
  logic        addr_match;
  logic        len_20;
  logic        kind_needs_ack;

  always_comb begin
    addr_match = (rx.addr1 == self_mac_addr);
    // rts and ps-poll are both 20 bytes on air
    len_20 = (rx.signal_len == 16'd20);
    kind = FK_OTHER;
    if (rx.fc_type == 2'b10) begin
      // subtype bit 3 marks qos data
      kind = rx.fc_subtype[3] ? FK_QOS_DATA : FK_DATA;
    end else if (rx.fc_type == 2'b00 && rx.fc_subtype != 4'b1110) begin
      kind = FK_MGMT;
    end else if (rx.fc_type == 2'b01) begin
      // control frames only count with the right length
      case (rx.fc_subtype)
        4'b1010: if (len_20) kind = FK_PSPOLL;
        4'b1011: if (len_20) kind = FK_RTS;
        4'b1101: if (rx.signal_len == ack_len) kind = FK_ACK;
        default: kind = FK_OTHER;
      endcase
    end
  end

  always_comb begin
    case (kind)
      FK_DATA, FK_MGMT, FK_PSPOLL: kind_needs_ack = 1'b1;
      // normal ack policy only
      FK_QOS_DATA: kind_needs_ack = (rx.qos_ack_policy == 2'b00);
      FK_RTS: kind_needs_ack = !cts_torts_disable;
      default: kind_needs_ack = 1'b0;
    endcase
  end

  assign ack_needed = rx.fcs_valid && addr_match && kind_needs_ack;
  assign ack_for_me = (kind == FK_ACK) && addr_match;

  // response data, frozen once the fsm leaves idle
  always_ff @(posedge clk) begin
    if (capture) begin
      resp.ack_addr <= rx.addr2;
      // negative duration carries an aid and counts as zero
      resp.rx_duration <= rx.duration[`DUR_W-1] ? '0 : rx.duration;
      resp.is_rts <= (kind == FK_RTS);
      resp.dur_from_rx <= (kind == FK_RTS) ||
                          (rx.more_frag &&
                           (kind == FK_DATA || kind == FK_QOS_DATA || kind == FK_MGMT));
    end
  end

  // an incoming ack or block ack frame never gets a response of its own
  a_no_ack_to_ack : assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    (rx.fc_type == 2'b01 && rx.fc_subtype == 4'b1101) |-> !ack_needed);

endmodule

//--- tx_control_fsm.sv
// one shared timer for all waits; a retry limit of zero means fail on the first timeout
`timescale 1ns/1ns
`include "ack_ctrl_cfg.svh"

module tx_control_fsm (
  input  logic                       clk,
  input  logic                       reset_blk_ack_bitmap_mem,
  input  ack_ctrl_pkg::timing_cfg_t  tcfg,
  input  ack_ctrl_pkg::rx_frame_t    rx,
  input  logic                       ack_needed,
  input  logic                       ack_for_me,
  input  logic                       ack_disable,
  input  logic                       recv_ack_fcs_valid_disable,
  input  logic                       tx_pkt_need_ack,
  input  logic [`RETRY_W-1:0]        tx_pkt_retrans_limit,
  input  logic                       phy_tx_done,
  input  logic                       pulse_tx_bb_end,
  input  logic                       cts_toself_bb_is_ongoing,
  input  logic                       backoff_done,
  input  logic                       quit_retrans,
  output logic                       capture,
  output logic                       tx_control_state_idle,
  output logic                       ack_cts_is_ongoing,
  output logic                       retrans_in_progress,
  output logic                       start_tx_ack,
  output logic                       retrans_trigger,
  output logic                       start_retrans,
  output logic                       tx_try_complete,
  output ack_ctrl_pkg::tx_status_t   tx_status
);
  import ack_ctrl_pkg::*;

  localparam logic [15:0] ack_len = `ACK_SIGNAL_LEN;
  // airtime of the ack body in clocks
  localparam logic [`TIMER_W-1:0] ack_wait_base = `ACK_N_SYM * 4 * `NUM_CLK_PER_US;

  ctrl_state_e         state;
  logic [`TIMER_W-1:0] timer;
  logic [`TIMER_W-1:0] timer_top;
  logic [`RETRY_W-1:0] num_retrans;
  logic [`RETRY_W-1:0] retrans_limit;
  logic                retrans_started;
  logic                wait_hit;
  logic                retry_exhausted;

  assign capture = (state == IDLE);
  assign tx_control_state_idle = (state == IDLE) && !retrans_started;
  assign ack_cts_is_ongoing = (state == PREP_ACK) || (state == SEND_ACK);

  always_comb begin
    retrans_limit = (tcfg.max_num_retrans != '0) ? tcfg.max_num_retrans : tx_pkt_retrans_limit;
    retry_exhausted = (num_retrans == retrans_limit) || (retrans_limit == '0);
    // sig wait and ack wait share the timer and the hit/timeout logic
    if (state == RECV_ACK) begin
      timer_top = ack_wait_base + tcfg.recv_ack_timeout_top_adj;
      wait_hit = ack_for_me && (rx.fcs_in_strobe || recv_ack_fcs_valid_disable);
    end else begin
      timer_top = tcfg.recv_ack_sig_valid_timeout_top;
      wait_hit = rx.sig_valid && (rx.signal_len == ack_len);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_blk_ack_bitmap_mem) begin
      state <= IDLE;
      timer <= '0;
      num_retrans <= '0;
      retrans_started <= 1'b0;
      retrans_in_progress <= 1'b0;
      start_tx_ack <= 1'b0;
      retrans_trigger <= 1'b0;
      start_retrans <= 1'b0;
      tx_try_complete <= 1'b0;
      tx_status <= '0;
    end else begin
      // pulses default low
      start_tx_ack <= 1'b0;
      retrans_trigger <= 1'b0;
      start_retrans <= 1'b0;
      tx_try_complete <= 1'b0;
      case (state)
        IDLE: begin
          timer <= '0;
          if (ack_needed && !ack_disable) begin
            state <= PREP_ACK;
          end else if (phy_tx_done && !cts_toself_bb_is_ongoing) begin
            // tx end of our own frame, not of an ack we sent
            state <= RECV_ACK_JUDGE;
          end else if (quit_retrans && retrans_in_progress) begin
            tx_try_complete <= 1'b1;
            tx_status <= '{acked: 1'b0, num_retrans: num_retrans};
            num_retrans <= '0;
            retrans_in_progress <= 1'b0;
            retrans_started <= 1'b0;
          end else if (backoff_done && retrans_in_progress && !retrans_started) begin
            state <= RECV_ACK_WAIT_BACKOFF_DONE;
          end
        end
        PREP_ACK: begin
          // sifs turnaround
          if (timer != tcfg.send_ack_wait_top) begin
            timer <= timer + 1'b1;
          end else begin
            start_tx_ack <= 1'b1;
            state <= SEND_ACK;
          end
        end
        SEND_ACK: begin
          if (phy_tx_done) state <= IDLE;
        end
        RECV_ACK_JUDGE: begin
          retrans_started <= 1'b0;
          if (tx_pkt_need_ack) begin
            retrans_in_progress <= 1'b1;
            state <= RECV_ACK_WAIT_TX_BB_DONE;
          end else begin
            // nothing to wait for, report success right away
            tx_try_complete <= 1'b1;
            tx_status <= '{acked: 1'b1, num_retrans: num_retrans};
            num_retrans <= '0;
            retrans_in_progress <= 1'b0;
            state <= IDLE;
          end
        end
        RECV_ACK_WAIT_TX_BB_DONE: begin
          if (pulse_tx_bb_end) state <= RECV_ACK_WAIT_SIG_VALID;
        end
        RECV_ACK_WAIT_SIG_VALID, RECV_ACK: begin
          timer <= timer + 1'b1;
          if (wait_hit && (timer < timer_top)) begin
            timer <= '0;
            if (state == RECV_ACK_WAIT_SIG_VALID) begin
              state <= RECV_ACK;
            end else begin
              tx_try_complete <= 1'b1;
              tx_status <= '{acked: 1'b1, num_retrans: num_retrans};
              num_retrans <= '0;
              retrans_in_progress <= 1'b0;
              state <= IDLE;
            end
          end else if (timer == timer_top) begin
            state <= IDLE;
            if (retry_exhausted) begin
              tx_try_complete <= 1'b1;
              tx_status <= '{acked: 1'b0, num_retrans: num_retrans};
              num_retrans <= '0;
              retrans_in_progress <= 1'b0;
            end else begin
              num_retrans <= num_retrans + 1'b1;
              retrans_trigger <= 1'b1;
            end
          end
        end
        RECV_ACK_WAIT_BACKOFF_DONE: begin
          state <= IDLE;
          if (quit_retrans) begin
            tx_try_complete <= 1'b1;
            tx_status <= '{acked: 1'b0, num_retrans: num_retrans};
            num_retrans <= '0;
            retrans_in_progress <= 1'b0;
            retrans_started <= 1'b0;
          end else if (backoff_done) begin
            start_retrans <= 1'b1;
            retrans_started <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_start_tx_ack_pulse : assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    start_tx_ack |=> !start_tx_ack);
  a_try_complete_pulse : assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    tx_try_complete |=> !tx_try_complete);
  a_tx_ack_in_resp : assert property (@(posedge clk) disable iff (reset_blk_ack_bitmap_mem)
    start_tx_ack |-> ack_cts_is_ongoing);

endmodule
